// File: Bender.yml
package:
  name: sub_mcu

sources:
  - design/sub_pkg.sv
  - design/nmi_latch.sv
  - design/sub_addr_decode.sv
  - design/shared_dpram.sv
  - design/rom_fetch.sv
  - design/sub_sequencer.sv
  - design/sub_mcu_top.sv
  - target: test
    files:
      - dv/tb_rom_model.sv
      - dv/tb_sub_mcu.sv

// File: all.f
design/sub_pkg.sv
design/nmi_latch.sv
design/sub_addr_decode.sv
design/shared_dpram.sv
design/rom_fetch.sv
design/sub_sequencer.sv
design/sub_mcu_top.sv
dv/tb_rom_model.sv
dv/tb_sub_mcu.sv

// File: design/nmi_latch.sv
`timescale 1ns/1ps
// NMI request latch
// Rising edge on the trigger sets pending, the acknowledge strobe clears it

module nmi_latch (
    input  logic mcu_halt,
    input  logic arst_n,
    input  logic trig_edge,   // Level from main CPU side
    input  logic clr,         // NMI acknowledge access
    output logic pending
);

    logic trig_q;
    logic trig_rise;

    assign trig_rise = trig_edge && !trig_q;

    always_ff @(posedge mcu_halt or negedge arst_n) begin
        if (!arst_n) begin
            trig_q  <= 1'b0;
            pending <= 1'b0;
        end else begin
            trig_q <= trig_edge;
            if (clr)
                pending <= 1'b0;      // Ack has priority
            else if (trig_rise)
                pending <= 1'b1;
        end
    end

    // An acknowledge always leaves the latch clear in the next cycle
    a_clr_wins: assert property (
        @(posedge mcu_halt) disable iff (!arst_n)
        clr |=> !pending
    ) else $error("nmi_latch: pending set in a cycle with clr high");

endmodule

// File: design/rom_fetch.sv
`timescale 1ns/1ps
// ROM access stage
// Valid/ready handshake with the external ROM: rom_cs held with a stable
// address until rom_ok, data captured and a one-cycle done strobe issued

module rom_fetch (
    input  logic                       mcu_halt,
    input  logic                       arst_n,
    input  logic                       fetch_req,
    input  logic [sub_pkg::addr_w-1:0] fetch_addr,
    input  logic [sub_pkg::data_w-1:0] rom_data,
    input  logic                       rom_ok,
    output logic                       rom_cs,
    output logic [sub_pkg::addr_w-1:0] rom_addr,
    output logic [sub_pkg::data_w-1:0] fetch_data,
    output logic                       fetch_done
);

    logic start;
    logic hs;

    // No restart while the requester still sees the done strobe
    assign start = fetch_req && !rom_cs && !fetch_done;
    assign hs    = rom_cs && rom_ok;   // Handshake cycle

    always_ff @(posedge mcu_halt or negedge arst_n) begin
        if (!arst_n) begin
            rom_cs     <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= hs;          // Single pulse after handshake
            if (start)
                rom_cs <= 1'b1;
            else if (hs)
                rom_cs <= 1'b0;        // Dropped in the following cycle
        end
    end

    // Address and data payload
    always_ff @(posedge mcu_halt) begin
        if (start)
            rom_addr <= fetch_addr;    // Held until rom_ok
        if (hs)
            fetch_data <= rom_data;
    end

    // ROM may take any number of cycles, address must not move meanwhile
    a_addr_hold: assert property (
        @(posedge mcu_halt) disable iff (!arst_n)
        (rom_cs && !rom_ok) |=> (rom_cs && $stable(rom_addr))
    ) else $error("rom_fetch: rom_addr moved while waiting for rom_ok");

endmodule

// File: design/shared_dpram.sv
`timescale 1ns/1ps
// Shared RAM between sub MCU and main CPU
// True dual port, registered reads, main writes only while bus is granted

module shared_dpram (
    input  logic                          mcu_halt,
    // Port 0, sub MCU
    input  logic [sub_pkg::shared_aw-1:0] addr0,
    input  logic [sub_pkg::data_w-1:0]    wdata0,
    input  logic                          we0,
    output logic [sub_pkg::data_w-1:0]    rdata0,
    // Port 1, main CPU
    input  logic [sub_pkg::shared_aw-1:0] addr1,
    input  logic [sub_pkg::data_w-1:0]    wdata1,
    input  logic                          main_we_req,   // com_cs and write strobe
    input  logic                          granted,       // Sub bus handed over
    output logic [sub_pkg::data_w-1:0]    rdata1
);

    localparam int depth = 1 << sub_pkg::shared_aw;

    logic [sub_pkg::data_w-1:0] mem [depth];
    logic                       we1;

    assign we1 = main_we_req && granted;   // Write gate on the main side

    always_ff @(posedge mcu_halt) begin
        if (we0)
            mem[addr0] <= wdata0;
        if (we1)
            mem[addr1] <= wdata1;
    end

    // Both ports read every cycle, data one cycle later
    always_ff @(posedge mcu_halt) begin
        rdata0 <= mem[addr0];
        rdata1 <= mem[addr1];
    end

    // Bus hold keeps the two masters apart
    a_no_collide: assert property (
        @(posedge mcu_halt)
        !(we0 && we1 && (addr0 == addr1))
    ) else $error("shared_dpram: both ports write address %h", addr0);

endmodule

// File: design/sub_addr_decode.sv
`timescale 1ns/1ps
// Sub bus address decoder
// Splits the 64 KB map into ROM, shared RAM, NMI ack and main irq pages
// and muxes the read data back to the bus master

module sub_addr_decode (
    input  logic [sub_pkg::addr_w-1:0] bus_addr,
    input  logic                       bus_mreq,
    input  logic [sub_pkg::data_w-1:0] rom_data,
    input  logic [sub_pkg::data_w-1:0] ram_rdata,
    output logic                       rom_sel,
    output logic                       shared_sel,
    output logic                       nmi_ack,
    output logic                       irq_main,
    output logic [sub_pkg::data_w-1:0] bus_rdata
);

    // Page decode during a memory request only
    always_comb begin
        rom_sel    = 1'b0;
        shared_sel = 1'b0;
        nmi_ack    = 1'b0;
        irq_main   = 1'b0;
        if (bus_mreq) begin
            if (bus_addr[sub_pkg::addr_w-1 -: 2] != sub_pkg::rom_top_page) begin
                rom_sel = 1'b1;                                      // Below 0xC000
            end else begin
                case (bus_addr[sub_pkg::addr_w-3 -: 2])
                    sub_pkg::page_shared:   shared_sel = 1'b1;
                    sub_pkg::page_nmi_ack:  nmi_ack    = 1'b1;
                    sub_pkg::page_irq_main: irq_main   = 1'b1;
                    default: ;                                       // 0xFxxx open
                endcase
            end
        end
    end

    // Read data mux
    always_comb begin
        if (rom_sel)
            bus_rdata = rom_data;
        else if (shared_sel)
            bus_rdata = ram_rdata;
        else
            bus_rdata = sub_pkg::open_bus;
    end

    // Selects are mutually exclusive
    always_comb begin
        a_one_sel: assert final (
            $onehot0({rom_sel, shared_sel, nmi_ack, irq_main})
        ) else $error("sub_addr_decode: bad select set for addr %h", bus_addr);
    end

endmodule

// File: design/sub_mcu_top.sv
`timescale 1ns/1ps
// Sub-processor block
// Sub MCU, ROM fetch stage, address decode, NMI latch and shared RAM

module sub_mcu_top (
    input  logic                          mcu_halt,
    input  logic                          arst_n,
    // Main CPU side
    input  logic [sub_pkg::shared_aw-1:0] main_addr,
    input  logic                          main_wrn,
    input  logic [sub_pkg::data_w-1:0]    main_dout,
    input  logic                          com_cs,
    input  logic                          main_busrq,
    input  logic                          mcu_nmi_set,
    output logic [sub_pkg::data_w-1:0]    shared_dout,
    output logic                          bus_ack,
    output logic                          mcu_irqmain,
    // ROM side
    output logic [sub_pkg::addr_w-1:0]    rom_addr,
    output logic                          rom_cs,
    input  logic [sub_pkg::data_w-1:0]    rom_data,
    input  logic                          rom_ok
);

    logic [sub_pkg::addr_w-1:0] bus_addr;
    logic                       bus_mreq;
    logic                       bus_wr;
    logic [sub_pkg::data_w-1:0] bus_wdata;
    logic [sub_pkg::data_w-1:0] bus_rdata;
    logic                       rom_sel;
    logic                       shared_sel;
    logic                       nmi_ack;
    logic                       nmi_pending;
    logic [sub_pkg::data_w-1:0] ram_rdata;
    logic                       fetch_req;
    logic [sub_pkg::data_w-1:0] fetch_data;
    logic                       fetch_done;

    nmi_latch u_nmi (
        .mcu_halt  (mcu_halt),
        .arst_n    (arst_n),
        .trig_edge (mcu_nmi_set),
        .clr       (nmi_ack),
        .pending   (nmi_pending)
    );

    sub_addr_decode u_decode (
        .bus_addr   (bus_addr),
        .bus_mreq   (bus_mreq),
        .rom_data   (rom_data),
        .ram_rdata  (ram_rdata),
        .rom_sel    (rom_sel),
        .shared_sel (shared_sel),
        .nmi_ack    (nmi_ack),
        .irq_main   (mcu_irqmain),   // High for every 0xExxx access cycle
        .bus_rdata  (bus_rdata)
    );

    shared_dpram u_shared (
        .mcu_halt    (mcu_halt),
        .addr0       (bus_addr[sub_pkg::shared_aw-1:0]),
        .wdata0      (bus_wdata),
        .we0         (bus_wr && shared_sel),
        .rdata0      (ram_rdata),
        .addr1       (main_addr),
        .wdata1      (main_dout),
        .main_we_req (com_cs && !main_wrn),
        .granted     (bus_ack),
        .rdata1      (shared_dout)
    );

    rom_fetch u_rom (
        .mcu_halt   (mcu_halt),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (bus_addr),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .fetch_data (fetch_data),
        .fetch_done (fetch_done)
    );

    sub_sequencer u_seq (
        .mcu_halt    (mcu_halt),
        .arst_n      (arst_n),
        .nmi_pending (nmi_pending),
        .hold_req    (main_busrq),
        .rom_sel     (rom_sel),
        .shared_sel  (shared_sel),
        .bus_rdata   (bus_rdata),
        .fetch_data  (fetch_data),
        .fetch_done  (fetch_done),
        .bus_addr    (bus_addr),
        .bus_mreq    (bus_mreq),
        .bus_wr      (bus_wr),
        .bus_wdata   (bus_wdata),
        .fetch_req   (fetch_req),
        .bus_ack     (bus_ack)
    );

endmodule

// File: design/sub_pkg.sv
// Sub-processor shared definitions
// Address map pages, opcode bytes, bus widths and start vectors

package sub_pkg;

    // Bus widths
    localparam int addr_w    = 16;
    localparam int data_w    = 8;
    localparam int shared_aw = 10;   // 1 KB shared RAM

    // A[15:14] of the non-ROM region, 0xC000 and up
    localparam logic [1:0] rom_top_page = 2'b11;

    // A[13:12] pages inside 0xC000..0xFFFF
    localparam logic [1:0] page_shared   = 2'b00;   // 0xCxxx
    localparam logic [1:0] page_nmi_ack  = 2'b01;   // 0xDxxx
    localparam logic [1:0] page_irq_main = 2'b10;   // 0xExxx

    // Start addresses
    localparam logic [addr_w-1:0] reset_vector = 16'h0000;
    localparam logic [addr_w-1:0] nmi_vector   = 16'h0066;   // Z80 NMI entry

    // Opcode bytes, 16-bit operands follow low byte first
    localparam logic [data_w-1:0] op_ldi  = 8'h01;   // acc <= imm
    localparam logic [data_w-1:0] op_ld   = 8'h02;   // acc <= mem[addr]
    localparam logic [data_w-1:0] op_st   = 8'h03;   // mem[addr] <= acc
    localparam logic [data_w-1:0] op_jp   = 8'h04;   // pc <= addr
    localparam logic [data_w-1:0] op_inc  = 8'h05;   // acc <= acc + 1
    localparam logic [data_w-1:0] op_retn = 8'h06;   // pc <= saved pc
    // Anything else runs as a one-byte no-op

    // Unmapped reads float high
    localparam logic [data_w-1:0] open_bus = 8'hff;

endpackage

// File: design/sub_sequencer.sv
`timescale 1ns/1ps
// Sub MCU bus master
// Compact six-opcode sequencer with Z80-like bus timing
// Waits on the ROM and takes NMI and bus hold only at instruction boundaries

module sub_sequencer (
    input  logic                       mcu_halt,
    input  logic                       arst_n,
    input  logic                       nmi_pending,
    input  logic                       hold_req,     // Main CPU bus request
    input  logic                       rom_sel,
    input  logic                       shared_sel,
    input  logic [sub_pkg::data_w-1:0] bus_rdata,
    input  logic [sub_pkg::data_w-1:0] fetch_data,
    input  logic                       fetch_done,
    output logic [sub_pkg::addr_w-1:0] bus_addr,
    output logic                       bus_mreq,
    output logic                       bus_wr,
    output logic [sub_pkg::data_w-1:0] bus_wdata,
    output logic                       fetch_req,
    output logic                       bus_ack
);

    typedef enum logic [2:0] {
        st_boundary,   // Hold and NMI checked here
        st_opcode,
        st_operand,
        st_mem,
        st_held
    } state_t;

    state_t                     state;
    logic [sub_pkg::addr_w-1:0] pc;
    logic [sub_pkg::addr_w-1:0] saved_pc;    // Return address for RETN
    logic [sub_pkg::addr_w-1:0] oper_addr;
    logic [sub_pkg::data_w-1:0] acc;
    logic [sub_pkg::data_w-1:0] ir;
    logic                       hi_byte;     // Next operand is the high byte
    logic                       ram_phase;   // Shared RAM data cycle
    logic                       rom_rd;
    logic                       done;
    logic                       has_operand;
    logic                       nmi_entry;
    logic [sub_pkg::data_w-1:0] rd_data;

    // Bus outputs straight from state
    assign bus_mreq  = (state == st_opcode) || (state == st_operand) || (state == st_mem);
    assign bus_wr    = (state == st_mem) && (ir == sub_pkg::op_st);
    assign bus_addr  = (state == st_mem) ? oper_addr : pc;
    assign bus_wdata = acc;
    assign bus_ack   = (state == st_held);

    assign rom_rd    = rom_sel && !bus_wr;   // ROM writes fall through
    assign fetch_req = bus_mreq && rom_rd;
    assign rd_data   = rom_rd ? fetch_data : bus_rdata;
    assign nmi_entry = (state == st_boundary) && !hold_req && nmi_pending;

    assign has_operand = (rd_data == sub_pkg::op_ldi) || (rd_data == sub_pkg::op_ld) ||
                         (rd_data == sub_pkg::op_st)  || (rd_data == sub_pkg::op_jp);

    // Access done on ROM handshake or second RAM cycle and at once otherwise
    always_comb begin
        if (rom_rd)
            done = fetch_done;
        else if (shared_sel)
            done = ram_phase;
        else
            done = 1'b1;
    end

    always_ff @(posedge mcu_halt or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_boundary;
            pc        <= sub_pkg::reset_vector;
            hi_byte   <= 1'b0;
            ram_phase <= 1'b0;
        end else begin
            ram_phase <= bus_mreq && shared_sel && !ram_phase;
            case (state)
                st_boundary: begin
                    if (hold_req) begin
                        state <= st_held;              // Stop requesting
                    end else begin
                        if (nmi_pending)
                            pc <= sub_pkg::nmi_vector;
                        state <= st_opcode;
                    end
                end
                st_opcode: if (done) begin
                    pc      <= pc + 1'b1;
                    hi_byte <= 1'b0;
                    state   <= has_operand ? st_operand : st_boundary;
                    if (rd_data == sub_pkg::op_retn)
                        pc <= saved_pc;
                end
                st_operand: if (done) begin
                    pc      <= pc + 1'b1;
                    hi_byte <= 1'b1;
                    if (ir == sub_pkg::op_ldi) begin
                        state <= st_boundary;
                    end else if (hi_byte) begin
                        if (ir == sub_pkg::op_jp) begin
                            pc    <= {rd_data, oper_addr[sub_pkg::data_w-1:0]};
                            state <= st_boundary;
                        end else begin
                            state <= st_mem;
                        end
                    end
                end
                st_mem:  if (done) state <= st_boundary;
                st_held: if (!hold_req) state <= st_boundary;   // Ack drops next cycle
                default: state <= st_boundary;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge mcu_halt) begin
        if (nmi_entry)
            saved_pc <= pc;
        if (done) begin
            case (state)
                st_opcode: begin
                    ir <= rd_data;
                    if (rd_data == sub_pkg::op_inc)
                        acc <= acc + 1'b1;
                end
                st_operand: begin
                    if (ir == sub_pkg::op_ldi)
                        acc <= rd_data;
                    else if (!hi_byte)
                        oper_addr[sub_pkg::data_w-1:0] <= rd_data;   // Low byte first
                    else
                        oper_addr[sub_pkg::addr_w-1:sub_pkg::data_w] <= rd_data;
                end
                st_mem: if (ir == sub_pkg::op_ld) acc <= rd_data;
                default: ;
            endcase
        end
    end

    // No requests while the bus is granted
    a_quiet_held: assert property (
        @(posedge mcu_halt) disable iff (!arst_n)
        bus_ack |-> !bus_mreq
    ) else $error("sub_sequencer: bus request while bus_ack is high");

endmodule

// File: dv/tb_rom_model.sv
`timescale 1ns/1ps
// ROM model for the sub MCU
// Program image, ready raised 0 to 3 cycles after a request is seen

module tb_rom_model (
    input  logic                       mcu_halt,
    input  logic                       arst_n,
    input  logic                       rom_cs,
    input  logic [sub_pkg::addr_w-1:0] rom_addr,
    output logic [sub_pkg::data_w-1:0] rom_data,
    output logic                       rom_ok,
    output logic                       req_live,   // Request seen, not yet answered
    output logic [sub_pkg::addr_w-1:0] req_addr    // Address taken at request start
);

    logic [sub_pkg::data_w-1:0] image [256];   // Program sits below 0x0100
    integer                     seed;
    int                         wait_left;
    logic                       busy;

    initial begin
        seed     = 32'hc1e9_bc5a;
        rom_data = '0;
        rom_ok   = 1'b0;
        for (int i = 0; i < 256; i++)
            image[i] = 8'h00;                  // Unprogrammed bytes run as no-ops
        // Main program
        image[8'h00] = sub_pkg::op_ldi;        // LDI 5A
        image[8'h01] = 8'h5a;
        image[8'h02] = sub_pkg::op_st;         // ST C010
        image[8'h03] = 8'h10;
        image[8'h04] = 8'hc0;
        image[8'h05] = sub_pkg::op_ld;         // LD C020
        image[8'h06] = 8'h20;
        image[8'h07] = 8'hc0;
        image[8'h08] = sub_pkg::op_inc;
        image[8'h09] = sub_pkg::op_st;         // ST C021
        image[8'h0a] = 8'h21;
        image[8'h0b] = 8'hc0;
        image[8'h0c] = sub_pkg::op_jp;         // JP 000C, spins here
        image[8'h0d] = 8'h0c;
        image[8'h0e] = 8'h00;
        // NMI handler at 0x0066
        image[8'h66] = sub_pkg::op_st;         // ST D000 clears the NMI latch
        image[8'h67] = 8'h00;
        image[8'h68] = 8'hd0;
        image[8'h69] = sub_pkg::op_st;         // ST E000 pulses the main irq
        image[8'h6a] = 8'h00;
        image[8'h6b] = 8'he0;
        image[8'h6c] = sub_pkg::op_retn;
    end

    // Samples at the edge, answers 2 ns later
    always @(posedge mcu_halt or negedge arst_n) begin
        if (!arst_n) begin
            busy      = 1'b0;
            wait_left = 0;
            rom_ok   <= 1'b0;
            req_live <= 1'b0;
        end else if (rom_cs && rom_ok) begin
            busy = 1'b0;                       // Handshake taken at this edge
            rom_ok   <= #2 1'b0;
            req_live <= #2 1'b0;
        end else if (rom_cs) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $random(seed) & 3;
                req_addr <= #2 rom_addr;
                req_live <= #2 1'b1;
            end
            if (wait_left == 0) begin
                rom_data <= #2 image[rom_addr[7:0]];
                rom_ok   <= #2 1'b1;
            end else begin
                wait_left = wait_left - 1;     // Still busy
            end
        end
    end

endmodule

// File: dv/tb_sub_mcu.sv
`timescale 1ns/1ps
// Testbench for the sub-processor block
// Bus hold and shared RAM access from the main side, NMI round trip
// through the handler, ROM valid/ready handshake under random delays

module tb_sub_mcu;

    localparam logic [sub_pkg::addr_w-1:0] loop_lo = 16'h000c;   // JP to itself
    localparam logic [sub_pkg::addr_w-1:0] loop_hi = 16'h000e;
    localparam int timeout   = 400;   // Cycles per wait
    localparam int ev_ack_hi = 0;
    localparam int ev_ack_lo = 1;
    localparam int ev_loop   = 2;
    localparam int ev_irq    = 3;

    logic                          mcu_halt;
    logic                          arst_n;
    logic [sub_pkg::shared_aw-1:0] main_addr;
    logic                          main_wrn;
    logic [sub_pkg::data_w-1:0]    main_dout;
    logic                          com_cs;
    logic                          main_busrq;
    logic                          mcu_nmi_set;
    logic [sub_pkg::data_w-1:0]    shared_dout;
    logic                          bus_ack;
    logic                          mcu_irqmain;
    logic [sub_pkg::addr_w-1:0]    rom_addr;
    logic                          rom_cs;
    logic [sub_pkg::data_w-1:0]    rom_data;
    logic                          rom_ok;
    logic                          req_live;
    logic [sub_pkg::addr_w-1:0]    req_addr;
    logic                          dout_chk;    // Readback compare enable
    logic [sub_pkg::data_w-1:0]    dout_exp;
    logic                          hold_chk;    // ROM address frozen
    logic [sub_pkg::addr_w-1:0]    hold_addr;
    logic                          irq_armed;   // One main irq allowed

    sub_mcu_top dut (.*);
    tb_rom_model rom (.*);

    always #20 mcu_halt = ~mcu_halt;   // 40 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic next_cycle();
        @(posedge mcu_halt);
        #2;
    endtask

    function automatic logic reached(input int ev);
        case (ev)
            ev_ack_hi: return bus_ack === 1'b1;
            ev_ack_lo: return bus_ack === 1'b0;
            ev_loop:   return rom_cs === 1'b1 && rom_addr >= loop_lo && rom_addr <= loop_hi;
            default:   return mcu_irqmain === 1'b1;
        endcase
    endfunction

    // Polled mid-cycle with outputs settled
    task automatic wait_for(input int ev, input string what);
        int n;
        n = 0;
        @(negedge mcu_halt);
        while (!reached(ev)) begin
            n++;
            if (n > timeout)
                abort_run($sformatf("Timed out after %0d cycles waiting for %s", timeout, what));
            @(negedge mcu_halt);
        end
    endtask

    task automatic main_write(input logic [sub_pkg::shared_aw-1:0] a,
                              input logic [sub_pkg::data_w-1:0] d);
        next_cycle();
        main_addr = a;
        main_dout = d;
        com_cs    = 1'b1;
        main_wrn  = 1'b0;
        next_cycle();
        com_cs    = 1'b0;
        main_wrn  = 1'b1;
    endtask

    // Address cycle then data compared at the following edge
    task automatic main_read(input logic [sub_pkg::shared_aw-1:0] a,
                             input logic [sub_pkg::data_w-1:0] exp);
        next_cycle();
        main_addr = a;
        com_cs    = 1'b1;
        next_cycle();
        dout_exp  = exp;
        dout_chk  = 1'b1;
        next_cycle();
        dout_chk  = 1'b0;
        com_cs    = 1'b0;
    endtask

    task automatic take_bus();
        next_cycle();
        main_busrq = 1'b1;
        wait_for(ev_ack_hi, "bus_ack to rise");
        hold_addr = rom_addr;
        hold_chk  = 1'b1;
    endtask

    task automatic release_bus();
        next_cycle();
        hold_chk   = 1'b0;
        main_busrq = 1'b0;
        wait_for(ev_ack_lo, "bus_ack to fall");
    endtask

    // Quiet outputs in reset and in the first cycle after it
    a_reset: assert property (@(posedge mcu_halt)
        (!arst_n || !$past(arst_n)) |-> (!rom_cs && !bus_ack && !mcu_irqmain))
        else abort_run($sformatf(
            "[ERROR] %0t rom_cs/bus_ack/mcu_irqmain expected 0/0/0, got %b/%b/%b",
            $time, $sampled(rom_cs), $sampled(bus_ack), $sampled(mcu_irqmain)));

    a_dout: assert property (@(posedge mcu_halt) dout_chk |-> shared_dout == dout_exp)
        else abort_run($sformatf("[ERROR] %0t shared_dout expected %h, got %h",
                                 $time, $sampled(dout_exp), $sampled(shared_dout)));

    a_held_rom_idle: assert property (@(posedge mcu_halt) bus_ack |-> !rom_cs)
        else abort_run($sformatf("[ERROR] %0t rom_cs expected 0, got %b",
                                 $time, $sampled(rom_cs)));

    a_held_addr: assert property (@(posedge mcu_halt) hold_chk |-> rom_addr === hold_addr)
        else abort_run($sformatf("[ERROR] %0t rom_addr expected %h, got %h",
                                 $time, $sampled(hold_addr), $sampled(rom_addr)));

    a_irq_width: assert property (@(posedge mcu_halt) mcu_irqmain |=> !mcu_irqmain)
        else abort_run($sformatf("[ERROR] %0t mcu_irqmain expected 0, got %b",
                                 $time, $sampled(mcu_irqmain)));

    a_irq_once: assert property (@(posedge mcu_halt) $rose(mcu_irqmain) |-> irq_armed)
        else abort_run("mcu_irqmain pulsed without a pending NMI");

    // Address may not move before rom_ok
    a_rom_wait: assert property (@(posedge mcu_halt)
        (req_live && !rom_ok) |-> rom_addr === req_addr)
        else abort_run($sformatf("[ERROR] %0t rom_addr expected %h, got %h",
                                 $time, $sampled(req_addr), $sampled(rom_addr)));

    initial begin
        mcu_halt    = 1'b0;
        arst_n      = 1'b0;
        main_addr   = '0;
        main_wrn    = 1'b1;
        main_dout   = '0;
        com_cs      = 1'b0;
        main_busrq  = 1'b1;   // Main CPU owns the bus out of reset
        mcu_nmi_set = 1'b0;
        dout_chk    = 1'b0;
        dout_exp    = '0;
        hold_chk    = 1'b0;
        hold_addr   = '0;
        irq_armed   = 1'b0;
        repeat (4) @(posedge mcu_halt);
        #2;
        arst_n = 1'b1;

        // Preload the byte the program loads and let it run
        take_bus();
        main_write(10'h020, 8'h33);
        main_read(10'h020, 8'h33);
        release_bus();
        wait_for(ev_loop, "the program to reach its loop");

        // Not granted so the RAM keeps its old byte
        main_write(10'h010, 8'ha5);

        // Handler raises the main irq once and RETN returns to the loop
        next_cycle();
        mcu_nmi_set = 1'b1;
        irq_armed   = 1'b1;
        next_cycle();
        mcu_nmi_set = 1'b0;
        wait_for(ev_irq, "mcu_irqmain after the NMI");
        next_cycle();
        irq_armed = 1'b0;
        wait_for(ev_loop, "the loop after RETN");

        take_bus();
        main_read(10'h010, 8'h5a);            // LDI value survives
        main_read(10'h021, 8'h33 + 8'h01);    // LD, INC, ST
        release_bus();
        wait_for(ev_loop, "the loop after the hold");
        $display("sim passed");
        $finish;
    end

endmodule
